//--- logic/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// Address and data widths
`define CACHE_ADR_W      32
`define CACHE_WORD_W     32

// Sets and ways
`define CACHE_SETS       16
`define CACHE_WAYS       4

// Words per line, refill length
`define CACHE_LINE_WORDS 4

`endif

//--- logic/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // Address field widths, low to high
    localparam int BYTE_SEL_W = $clog2(`CACHE_WORD_W / 8);
    localparam int WORD_SEL_W = $clog2(`CACHE_LINE_WORDS);
    localparam int SET_W      = $clog2(`CACHE_SETS);
    localparam int TAG_W      = `CACHE_ADR_W - SET_W - WORD_SEL_W - BYTE_SEL_W;

    typedef logic [SET_W-1:0]                   set_idx_t;
    typedef logic [TAG_W-1:0]                   tag_t;
    typedef logic [WORD_SEL_W-1:0]              word_sel_t;
    typedef logic [BYTE_SEL_W-1:0]              byte_sel_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]     way_t;
    typedef logic [1:0]                         age_t;
    typedef logic [`CACHE_WORD_W-1:0]           word_t;

    // Word 0 sits in the low bits
    typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_W-1:0] line_t;

    typedef enum logic [1:0] {
        op_lw,
        op_lb,
        op_lbu,
        op_sw
    } cpu_op_t;

    // Load result from a full word
    function automatic word_t format_load(word_t wrd, byte_sel_t bsel, cpu_op_t op);
        logic [7:0] sel_byte;
        sel_byte = wrd[bsel*8 +: 8];
        case (op)
            op_lb:   return {{(`CACHE_WORD_W-8){sel_byte[7]}}, sel_byte};
            op_lbu:  return {{(`CACHE_WORD_W-8){1'b0}}, sel_byte};
            default: return wrd;
        endcase
    endfunction

endpackage

//--- logic/tag_if.sv
`timescale 1ns/100ps

interface tag_if;
    import cache_pkg::*;

    // Lookup request, held by the sequencer
    set_idx_t lookup_set;
    tag_t     lookup_tag;

    // Age update, plus tag and valid write when fill is set
    logic     upd_en;
    way_t     upd_way;
    logic     fill;

    // Results, one cycle after lookup_set
    logic     hit;
    way_t     hit_way;
    way_t     victim_way;
    logic     init_done;

    modport sequencer (
        output lookup_set, lookup_tag, upd_en, upd_way, fill,
        input  hit, hit_way, victim_way, init_done
    );

    modport store (
        input  lookup_set, lookup_tag, upd_en, upd_way, fill,
        output hit, hit_way, victim_way, init_done
    );

endinterface

//--- logic/data_if.sv
`timescale 1ns/100ps

interface data_if;
    import cache_pkg::*;

    // Line address
    set_idx_t  set;
    way_t      way;

    // Single word write
    word_sel_t word_sel;
    logic      wr_en;
    word_t     wr_dat;

    // Registered line, one cycle behind set and way
    line_t     rd_line;

    modport sequencer (
        output set, way, word_sel, wr_en, wr_dat,
        input  rd_line
    );

    modport store (
        input  set, way, word_sel, wr_en, wr_dat,
        output rd_line
    );

endinterface

//--- logic/cache_tag_store.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_tag_store (
    input logic  clk,
    input logic  rst,
    tag_if.store tif
);
    import cache_pkg::*;

    tag_t                   tag_q   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    age_t                   age_q   [`CACHE_SETS][`CACHE_WAYS];

    set_idx_t               rd_set;
    set_idx_t               clr_set;
    logic                   clearing;
    logic                   inv_found;
    age_t                   best_age;

    ////////////////////////////////////////
    // Clear sweep after reset
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            clearing <= 1'b1;
            clr_set  <= '0;
        end
        else if (clearing)
        begin
            clr_set <= clr_set + set_idx_t'(1);
            if (clr_set == set_idx_t'(`CACHE_SETS - 1))
                clearing <= 1'b0;
        end
    end

    assign tif.init_done = !clearing;

    ////////////////////////////////////////
    // Array updates
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        rd_set <= tif.lookup_set;
        if (clearing)
        begin
            valid_q[clr_set] <= '0;
            for (int w = 0; w < `CACHE_WAYS; w++)
                age_q[clr_set][w] <= '0;
        end
        else if (tif.upd_en)
        begin
            // Accessed way becomes youngest, the rest age up to 3
            for (int w = 0; w < `CACHE_WAYS; w++)
            begin
                if (way_t'(w) == tif.upd_way)
                    age_q[tif.lookup_set][w] <= '0;
                else if (age_q[tif.lookup_set][w] != 2'd3)
                    age_q[tif.lookup_set][w] <= age_q[tif.lookup_set][w] + age_t'(1);
            end
            if (tif.fill)
            begin
                tag_q[tif.lookup_set][tif.upd_way]   <= tif.lookup_tag;
                valid_q[tif.lookup_set][tif.upd_way] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Hit and victim
    ////////////////////////////////////////

    always_comb
    begin
        tif.hit        = 1'b0;
        tif.hit_way    = '0;
        tif.victim_way = '0;
        inv_found      = 1'b0;
        best_age       = '0;

        // Lowest matching way wins
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
        begin
            if (valid_q[rd_set][w] && tag_q[rd_set][w] == tif.lookup_tag)
            begin
                tif.hit     = 1'b1;
                tif.hit_way = way_t'(w);
            end
        end

        // First invalid way, else oldest with ties to the low index
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (!valid_q[rd_set][w] && !inv_found)
            begin
                inv_found      = 1'b1;
                tif.victim_way = way_t'(w);
            end
            else if (!inv_found && age_q[rd_set][w] > best_age)
            begin
                best_age       = age_q[rd_set][w];
                tif.victim_way = way_t'(w);
            end
        end
    end

endmodule

//--- logic/cache_data_store.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_data_store (
    input logic   clk,
    data_if.store dif
);
    import cache_pkg::*;

    localparam int ENTRIES = `CACHE_SETS * `CACHE_WAYS;

    // One line per set and way, way in the low index bits
    line_t                      mem [ENTRIES];
    logic [$clog2(ENTRIES)-1:0] idx;
    line_t                      line_nxt;

    assign idx = {dif.set, dif.way};

    ////////////////////////////////////////
    // Word merge
    ////////////////////////////////////////

    always_comb
    begin
        line_nxt = mem[idx];
        if (dif.wr_en)
            line_nxt[dif.word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] = dif.wr_dat;
    end

    ////////////////////////////////////////
    // Storage and registered read
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (dif.wr_en)
            mem[idx] <= line_nxt;
        // Read returns the merged line, so a refill's last word shows up
        dif.rd_line <= line_nxt;
    end

endmodule

//--- logic/cache_sequencer.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_sequencer (
    input  logic                     clk,
    input  logic                     rst,

    // CPU side
    input  logic                     cpu_req,
    input  cache_pkg::cpu_op_t       cpu_op,
    input  logic [`CACHE_ADR_W-1:0]  cpu_adr,
    input  cache_pkg::word_t         cpu_wdat,
    output logic                     cpu_ack,
    output cache_pkg::word_t         cpu_rdat,

    // Memory side
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [`CACHE_ADR_W-1:0]  mem_adr,
    output cache_pkg::word_t         mem_wdat,
    input  logic                     mem_ack,
    input  cache_pkg::word_t         mem_rdat,

    tag_if.sequencer                 tif,
    data_if.sequencer                dif
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_refill,
        st_store_wait
    } state_t;

    state_t    state;
    state_t    state_nxt;

    tag_t      req_tag;
    set_idx_t  req_set;
    word_sel_t req_word;
    byte_sel_t req_byte;

    way_t      way_q;
    way_t      cur_way;
    logic      hit_q;
    word_sel_t cnt;
    word_sel_t cnt_inc;
    logic      last_word;

    assign {req_tag, req_set, req_word, req_byte} = cpu_adr;

    // Refill wraps back to the critical word
    assign cnt_inc   = cnt + word_sel_t'(1);
    assign last_word = (cnt_inc == req_word);

    // Hit way is only known during lookup
    assign cur_way = (state == st_lookup) ? tif.hit_way : way_q;

    ////////////////////////////////////////
    // State and refill registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk)
    begin
        if (state == st_lookup)
        begin
            way_q <= tif.hit ? tif.hit_way : tif.victim_way;
            hit_q <= tif.hit;
            cnt   <= req_word;
        end
        else if (state == st_refill && mem_ack)
            cnt <= cnt_inc;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
                if (cpu_req && tif.init_done)
                    state_nxt = st_lookup;
            st_lookup:
                if (cpu_op == op_sw)
                    state_nxt = st_store_wait;
                else if (tif.hit)
                    state_nxt = st_respond;
                else
                    state_nxt = st_refill;
            st_refill:
                if (mem_ack && last_word)
                    state_nxt = st_respond;
            st_store_wait:
                if (mem_ack)
                    state_nxt = st_respond;
            default:
                state_nxt = st_idle;
        endcase
    end

    ////////////////////////////////////////
    // Tag and data store control
    ////////////////////////////////////////

    assign tif.lookup_set = req_set;
    assign tif.lookup_tag = req_tag;
    assign tif.upd_way    = cur_way;
    assign tif.fill       = (state == st_refill);

    // Load hit at lookup, refill at its last word, store hit at mem_ack
    assign tif.upd_en = (state == st_lookup && tif.hit && cpu_op != op_sw)
                     || (state == st_refill && mem_ack && last_word)
                     || (state == st_store_wait && mem_ack && hit_q);

    assign dif.set      = req_set;
    assign dif.way      = cur_way;
    assign dif.word_sel = (state == st_refill) ? cnt : req_word;
    assign dif.wr_dat   = (state == st_refill) ? mem_rdat : cpu_wdat;
    assign dif.wr_en    = (state == st_refill && mem_ack)
                       || (state == st_store_wait && mem_ack && hit_q);

    ////////////////////////////////////////
    // Memory and CPU ports
    ////////////////////////////////////////

    assign mem_req  = (state == st_refill) || (state == st_store_wait);
    assign mem_we   = (state == st_store_wait);
    assign mem_wdat = cpu_wdat;
    assign mem_adr  = (state == st_refill) ? {req_tag, req_set, cnt, byte_sel_t'(0)}
                                           : {req_tag, req_set, req_word, byte_sel_t'(0)};

    assign cpu_ack  = (state == st_respond);
    assign cpu_rdat = format_load(dif.rd_line[req_word*`CACHE_WORD_W +: `CACHE_WORD_W],
                                  req_byte, cpu_op);

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    // CPU port
    input  logic                     cpu_req,
    input  cache_pkg::cpu_op_t       cpu_op,
    input  logic [`CACHE_ADR_W-1:0]  cpu_adr,
    input  logic [`CACHE_WORD_W-1:0] cpu_wdat,
    output logic                     cpu_ack,
    output logic [`CACHE_WORD_W-1:0] cpu_rdat,

    // Memory port
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [`CACHE_ADR_W-1:0]  mem_adr,
    output logic [`CACHE_WORD_W-1:0] mem_wdat,
    input  logic                     mem_ack,
    input  logic [`CACHE_WORD_W-1:0] mem_rdat
);

    tag_if  i_tag_if ();
    data_if i_data_if ();

    cache_sequencer i_cache_sequencer (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_op   (cpu_op),
        .cpu_adr  (cpu_adr),
        .cpu_wdat (cpu_wdat),
        .cpu_ack  (cpu_ack),
        .cpu_rdat (cpu_rdat),
        .mem_req  (mem_req),
        .mem_we   (mem_we),
        .mem_adr  (mem_adr),
        .mem_wdat (mem_wdat),
        .mem_ack  (mem_ack),
        .mem_rdat (mem_rdat),
        .tif      (i_tag_if.sequencer),
        .dif      (i_data_if.sequencer)
    );

    cache_tag_store i_cache_tag_store (
        .clk (clk),
        .rst (rst),
        .tif (i_tag_if.store)
    );

    cache_data_store i_cache_data_store (
        .clk (clk),
        .dif (i_data_if.store)
    );

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [31:0] mem_adr,
    input  logic [31:0] mem_wdat,
    output logic        mem_ack,
    output logic [31:0] mem_rdat,
    output int          read_cnt
);

    logic [31:0] words [logic [31:0]];
    int unsigned delay_state = 32'h9459;
    bit          busy;
    int          wait_left;

    // LCG step whose upper bits give 0 to 3 wait cycles
    function automatic int next_delay();
        delay_state = delay_state * 32'd1103515245 + 32'd12345;
        return int'((delay_state >> 16) % 4);
    endfunction

    initial
    begin
        mem_ack  = 1'b0;
        mem_rdat = '0;
        read_cnt = 0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_ack  <= 1'b0;
            read_cnt <= 0;
            busy     = 1'b0;
        end
        // Skip the edge where the DUT moves to its next address
        else if (mem_ack)
            mem_ack <= 1'b0;
        else if (mem_req)
        begin
            if (!busy)
            begin
                busy      = 1'b1;
                wait_left = next_delay();
            end
            if (wait_left == 0)
            begin
                busy    = 1'b0;
                mem_ack <= 1'b1;
                if (mem_we)
                    words[mem_adr] = mem_wdat;
                else
                begin
                    // Unwritten words read as a pattern of their address
                    mem_rdat <= words.exists(mem_adr) ? words[mem_adr]
                                                      : mem_adr ^ 32'hA5A5_0000;
                    read_cnt <= read_cnt + 1;
                end
            end
            else
                wait_left--;
        end
    end

endmodule

//--- testbench/tb_cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module tb_cache_ctrl;
    import cache_pkg::*;

    typedef struct packed {
        cpu_op_t     op;
        logic [31:0] adr;
        word_t       wdat;
        word_t       exp_rdat;
        bit          exp_miss;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    cpu_op_t     cpu_op;
    logic [31:0] cpu_adr;
    word_t       cpu_wdat;
    logic        cpu_ack;
    word_t       cpu_rdat;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_adr;
    word_t       mem_wdat;
    logic        mem_ack;
    word_t       mem_rdat;
    int          read_cnt;

    entry_t      tbl[$];
    word_t       shadow_mem[logic [31:0]];
    tag_t        s_tag   [`CACHE_SETS][`CACHE_WAYS];
    bit          s_valid [`CACHE_SETS][`CACHE_WAYS];
    int          s_age   [`CACHE_SETS][`CACHE_WAYS];
    int unsigned rand_state = 32'h9459;
    bit          table_ready;
    int          data_err;
    int          miss_err;
    int          lat_err;
    int          hang_err;

    cache_ctrl i_cache_ctrl (.*);
    tb_mem_model i_mem_model (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Shadow model
    ////////////////////////////////////////

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 8;
    endfunction

    function automatic word_t mem_word(logic [31:0] adr);
        if (shadow_mem.exists(adr))
            return shadow_mem[adr];
        return adr ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t expected_load(word_t wrd, logic [1:0] bsel, cpu_op_t op);
        logic [7:0] b;
        b = 8'(wrd >> (8 * bsel));
        if (op == op_lbu)
            return {24'h0, b};
        if (op == op_lb)
            return word_t'(int'($signed(b)));
        return wrd;
    endfunction

    // Accessed way gets age 0, the others count up to 3
    function automatic void touch(int row, int way);
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (w == way)
                s_age[row][w] = 0;
            else if (s_age[row][w] < 3)
                s_age[row][w]++;
        end
    endfunction

    function automatic int pick_victim(int row);
        int best;
        best = 0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (!s_valid[row][w])
                return w;
            if (s_age[row][w] > s_age[row][best])
                best = w;
        end
        return best;
    endfunction

    task automatic add_entry(cpu_op_t op, logic [31:0] adr, word_t wdat);
        entry_t      e;
        int          row;
        int          way;
        logic [31:0] wadr;
        row  = int'(adr[7:4]);
        wadr = {adr[31:2], 2'b00};
        way  = -1;
        for (int w = 0; w < `CACHE_WAYS; w++)
            if (s_valid[row][w] && s_tag[row][w] == adr[31:8])
                way = w;
        e.op       = op;
        e.adr      = adr;
        e.wdat     = wdat;
        e.exp_miss = (way < 0);
        e.exp_rdat = '0;
        if (op == op_sw)
        begin
            // Write-through with no allocation on a miss
            shadow_mem[wadr] = wdat;
            if (way >= 0)
                touch(row, way);
        end
        else
        begin
            if (way < 0)
            begin
                way               = pick_victim(row);
                s_tag[row][way]   = adr[31:8];
                s_valid[row][way] = 1'b1;
            end
            touch(row, way);
            e.exp_rdat = expected_load(mem_word(wadr), adr[1:0], op);
        end
        tbl.push_back(e);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic build_table();
        int          order[9] = '{2, 4, 1, 3, 5, 2, 1, 3, 5};
        int unsigned r;
        cpu_op_t     op;
        logic [31:0] adr;
        // Miss on word 2, then the rest of the line hits
        for (int k = 0; k < 4; k++)
            add_entry(op_lw, 32'h1200 + 4 * ((k + 2) % 4), '0);
        for (int b = 0; b < 4; b++)
        begin
            add_entry(op_lb, 32'h1204 + b, '0);
            add_entry(op_lbu, 32'h1204 + b, '0);
        end
        add_entry(op_sw, 32'h1204, 32'h8081_7F00);
        add_entry(op_lw, 32'h1204, '0);
        add_entry(op_lb, 32'h1206, '0);
        add_entry(op_lbu, 32'h1207, '0);
        add_entry(op_sw, 32'h3340, 32'hCAFE_F00D);
        add_entry(op_lw, 32'h3340, '0);
        // Five lines into set 5, touches, a sixth line, then reloads
        for (int t = 0; t < 5; t++)
            add_entry(op_lw, 32'h4050 + t * 32'h100, '0);
        for (int k = 0; k < 9; k++)
            add_entry(op_lw, 32'h4050 + order[k] * 32'h100, '0);
        for (int i = 0; i < 60; i++)
        begin
            r   = next_rand();
            op  = cpu_op_t'(r % 4);
            adr = 32'h6000 + ((r / 4) % 6) * 32'h100 + (8 + (r / 32) % 3) * 32'h10
                + ((r / 128) % 4) * 4;
            if (op == op_lb || op == op_lbu)
                adr = adr + (r / 512) % 4;
            add_entry(op, adr, (next_rand() << 16) ^ next_rand());
        end
    endtask

    ////////////////////////////////////////
    // Apply and check
    ////////////////////////////////////////

    // Refill reads wrap from the critical word, a store writes its own word
    task automatic check_mem_access(int i, int n);
        logic [31:0] exp_adr;
        bit          exp_we;
        exp_we  = (tbl[i].op == op_sw);
        exp_adr = {tbl[i].adr[31:4], 2'(tbl[i].adr[3:2] + n), 2'b00};
        assert (mem_we == exp_we && mem_adr == exp_adr)
        else
        begin
            $display("MISMATCH at %0t: entry %0d access %0d adr %h we %b, expected %h %b",
                     $time, i, n, mem_adr, mem_we, exp_adr, exp_we);
            data_err++;
        end
        if (exp_we)
            assert (mem_wdat == tbl[i].wdat)
            else
            begin
                $display("MISMATCH at %0t: entry %0d wrote %h, expected %h",
                         $time, i, mem_wdat, tbl[i].wdat);
                data_err++;
            end
    endtask

    task automatic run_entry(int i);
        int start_reads;
        int exp_reads;
        int exp_acc;
        int n_acc;
        int last_acc;
        int cycles;
        bit got_ack;
        start_reads = read_cnt;
        exp_reads   = (tbl[i].op != op_sw && tbl[i].exp_miss) ? 4 : 0;
        exp_acc     = (tbl[i].op == op_sw) ? 1 : exp_reads;
        cpu_req  <= 1'b1;
        cpu_op   <= tbl[i].op;
        cpu_adr  <= tbl[i].adr;
        cpu_wdat <= tbl[i].wdat;
        cycles   = 0;
        n_acc    = 0;
        last_acc = 0;
        got_ack  = 1'b0;
        while (!got_ack && cycles < 80)
        begin
            @(posedge clk);
            cycles++;
            got_ack = cpu_ack;
            if (mem_req && mem_ack)
            begin
                check_mem_access(i, n_acc);
                n_acc++;
                last_acc = cycles;
            end
        end
        cpu_req <= 1'b0;
        assert (got_ack)
        else
        begin
            $display("Entry %0d at %0t was never acknowledged by the DUT", i, $time);
            hang_err++;
        end
        if (got_ack)
        begin
            assert (read_cnt - start_reads == exp_reads)
            else
            begin
                $display("MISMATCH at %0t: entry %0d made %0d memory reads, expected %0d",
                         $time, i, read_cnt - start_reads, exp_reads);
                miss_err++;
            end
            assert (n_acc == exp_acc)
            else
            begin
                $display("MISMATCH at %0t: entry %0d made %0d memory accesses, expected %0d",
                         $time, i, n_acc, exp_acc);
                miss_err++;
            end
            // Ack follows the last mem_ack by one cycle
            if (n_acc > 0)
                assert (cycles == last_acc + 1)
                else
                begin
                    $display("MISMATCH at %0t: entry %0d ack came %0d cycles after mem_ack",
                             $time, i, cycles - last_acc);
                    lat_err++;
                end
            if (tbl[i].op != op_sw)
            begin
                assert (cpu_rdat == tbl[i].exp_rdat)
                else
                begin
                    $display("MISMATCH at %0t: entry %0d adr %h read %h, expected %h",
                             $time, i, tbl[i].adr, cpu_rdat, tbl[i].exp_rdat);
                    data_err++;
                end
                // Ack sampled one edge after the cycle it was high in
                if (!tbl[i].exp_miss)
                    assert (cycles - 1 == 2)
                    else
                    begin
                        $display("MISMATCH at %0t: entry %0d hit took %0d cycles, expected 2",
                                 $time, i, cycles - 1);
                        lat_err++;
                    end
            end
        end
    endtask

    initial
    begin
        rst      = 1'b1;
        cpu_req  = 1'b0;
        cpu_op   = op_lw;
        cpu_adr  = '0;
        cpu_wdat = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < tbl.size() && hang_err == 0; i++)
        begin
            @(posedge clk);
            run_entry(i);
        end
        $display("Errors: data %0d, miss %0d, latency %0d, no ack %0d",
                 data_err, miss_err, lat_err, hang_err);
        if (data_err + miss_err + lat_err + hang_err == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        wait (table_ready);
        repeat (tbl.size() * 40 + 100) @(posedge clk);
        $display("Watchdog expired before the stimulus table was finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- cache_ctrl.f
+incdir+logic
logic/cache_pkg.sv
logic/tag_if.sv
logic/data_if.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_sequencer.sv
logic/cache_ctrl.sv
testbench/tb_mem_model.sv
testbench/tb_cache_ctrl.sv

//--- Makefile
SIM        := verilator
TOP        := tb_cache_ctrl
FILE_LIST  := cache_ctrl.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	$(SIM) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
